/* build.f */
+incdir+include
verilog/led_panel_pkg.sv
verilog/scan_timer.sv
verilog/pixel_write_queue.sv
verilog/frame_buffer.sv
verilog/subframe_pwm.sv
verilog/panel_driver.sv
verilog/led_panel_top.sv
verification/tb_led_panel.sv

/* Makefile */
TOP = tb_led_panel

all: run

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f build.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

/* verification/tb_led_panel.sv */
`timescale 1ns/1ps
`include "led_panel_macros.svh"

module tb_led_panel;

    localparam int N_ENTRIES       = 16;
    localparam int ROW_CYCLES      = 66;
    localparam int SUBFRAME_CYCLES = 32 * ROW_CYCLES;
    localparam int STEAL_PERIOD    = 16 * SUBFRAME_CYCLES;
    localparam int INIT_CYCLES     = 200;   // reset, two FM6126 words, startup
    localparam int TIMEOUT_CYCLES  = INIT_CYCLES + 40 * STEAL_PERIOD;

    logic                        clk;
    logic                        pll_locked;
    led_panel_pkg::pixel_write_t pix_wr;
    logic                        credit_return;
    led_panel_pkg::panel_out_t   panel;
    logic                        blank;
    logic                        latch;
    logic                        sclk;

    // stimulus table with one host write per entry
    logic        tab_half  [N_ENTRIES];
    logic [4:0]  tab_row   [N_ENTRIES];
    logic [5:0]  tab_col   [N_ENTRIES];
    logic [15:0] tab_pix   [N_ENTRIES];
    logic [23:0] tab_level [N_ENTRIES];   // expected 8 bit red, green, blue
    int          tab_seen  [N_ENTRIES];
    int          entry_at  [0:4095];      // entry index by {half, row, column} or -1

    int   n_errors = 0;
    int   n_checks = 0;
    int   cycle = 0;
    int   credits = `QUEUE_DEPTH;
    int   issued = 0;
    int   returned = 0;
    int   issue_cyc [$];
    logic colour_on = 1'b0;
    int   sf_seen = 0;

    // panel monitor state
    int          init_pulses = 0;
    int          init_latch1 = 0;
    int          init_latch2 = 0;
    int          row_pulses = 0;
    int          latch_n = 0;         // latches since the end of init
    int          last_latch_cyc = 0;
    logic        prev_latch = 1'b0;
    int          sf;
    int          key;
    int          idx;
    logic [7:0]  level_cmp;
    logic [15:0] init_word;

    led_panel_top i_dut (
        .clk           (clk),
        .pll_locked    (pll_locked),
        .pix_wr        (pix_wr),
        .credit_return (credit_return),
        .panel         (panel),
        .blank         (blank),
        .latch         (latch),
        .sclk          (sclk)
    );

    always #20 clk = ~clk;

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t ns: %s (got 0x%0h, expected 0x%0h)",
                     $time, msg, got, exp);
        end
    endtask

    function automatic logic [7:0] reverse_bits(input logic [7:0] v);
        logic [7:0] r;
        r = 8'd0;
        for (int i = 0; i < 8; i++) begin
            r = {r[6:0], v[i]};   // lsb ends up on top
        end
        return r;
    endfunction

    // rgb565 fields padded with zeros at the bottom
    function automatic logic [23:0] expand_levels(input logic [15:0] pix);
        logic [7:0] r8;
        logic [7:0] g8;
        logic [7:0] b8;
        r8 = {pix[15:11], 3'b000};
        g8 = {pix[10:5], 2'b00};
        b8 = {pix[4:0], 3'b000};
        return {r8, g8, b8};
    endfunction

    function automatic logic [2:0] expected_rgb(input logic [23:0] level, input logic [7:0] thr);
        return {level[23:16] > thr, level[15:8] > thr, level[7:0] > thr};
    endfunction

    task automatic build_table();
        logic [15:0] fixed_pix [8];
        fixed_pix = '{16'hFFFF, 16'h0000, 16'hF800, 16'h07E0,
                      16'h001F, 16'h8410, 16'h0841, 16'h7BEF};
        for (int k = 0; k < 4096; k++) begin
            entry_at[k] = -1;
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            tab_half[i] = i[0];
            tab_row[i]  = 5'((i * 7 + 3) % 32);
            tab_col[i]  = 6'((i * 13 + 5) % 64);   // distinct columns so entries never overlap
            if (i < 8) begin
                tab_pix[i] = fixed_pix[i];
            end else begin
                tab_pix[i] = 16'($urandom);
            end
            tab_level[i] = expand_levels(tab_pix[i]);
            tab_seen[i]  = 0;
            entry_at[{tab_half[i], tab_row[i], tab_col[i]}] = i;
        end
    endtask

    task automatic check_reset_state(input string when_txt);
        check_eq(blank, 1'b1, {"blank ", when_txt});
        check_eq(latch, 1'b0, {"latch ", when_txt});
        check_eq(sclk, 1'b0, {"sclk ", when_txt});
        check_eq({panel.rgb_upper, panel.rgb_lower}, 6'd0, {"rgb ", when_txt});
        check_eq(credit_return, 1'b0, {"credit_return ", when_txt});
    endtask

    initial begin
        clk        = 1'b0;
        pll_locked = 1'b0;
        pix_wr     = '0;
        void'($urandom(32'h037bb9ff));
        build_table();
        repeat (5) begin
            @(negedge clk);
            check_reset_state("during reset");
        end
        @(posedge clk);
        #2 pll_locked = 1'b1;
        @(posedge clk);   // first edge out of reset
        @(negedge clk);
        check_reset_state("after reset release");
        @(posedge clk);
        #2;
        for (int i = 0; i < N_ENTRIES; i++) begin
            while (credits == 0) begin   // hold off while out of credits
                @(posedge clk);
                #2;
            end
            pix_wr.valid  = 1'b1;
            pix_wr.half   = tab_half[i];
            pix_wr.row    = tab_row[i];
            pix_wr.column = tab_col[i];
            pix_wr.pixel  = tab_pix[i];
            credits--;
            issued++;
            issue_cyc.push_back(cycle);
            @(posedge clk);
            #2 pix_wr = '0;
        end
        wait (credits == `QUEUE_DEPTH);
        colour_on = 1'b1;
        wait (sf_seen >= 3);   // two full subframes after the last write
        check_eq(returned, issued, "credit returns against writes issued");
        for (int i = 0; i < N_ENTRIES; i++) begin
            check_eq(tab_seen[i] > 0, 1'b1, $sformatf("entry %0d never shown", i));
        end
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle++;
        if (cycle > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d  errors: %0d", n_checks, n_errors);
            $display("Finished with errors");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (pll_locked) begin
            if (credit_return) begin
                returned++;
                credits++;
                check_eq(credits <= `QUEUE_DEPTH, 1'b1, "credits above queue depth");
                check_eq(returned <= issued, 1'b1, "credit returned without a write");
                if (issue_cyc.size() > 0) begin
                    check_eq((cycle - issue_cyc.pop_front()) <= STEAL_PERIOD, 1'b1,
                             "credit later than one stolen-subframe period");
                end
            end
            if (init_pulses < 128) begin
                if (sclk) begin
                    init_word = (init_pulses < 64) ? `FM_REG1 : `FM_REG2;
                    check_eq({panel.rgb_upper, panel.rgb_lower},
                             {6{init_word[15 - init_pulses % 16]}},
                             $sformatf("init data on clock %0d", init_pulses));
                    check_eq(latch, (init_pulses % 64) >=
                             64 - ((init_pulses < 64) ? `FM_LATCH1 : `FM_LATCH2),
                             $sformatf("init latch on clock %0d", init_pulses));
                    if (latch && init_pulses < 64) begin
                        init_latch1++;
                    end else if (latch) begin
                        init_latch2++;
                    end
                    init_pulses++;
                    if (init_pulses == 128) begin
                        check_eq(init_latch1, `FM_LATCH1, "latched clocks of register 1");
                        check_eq(init_latch2, `FM_LATCH2, "latched clocks of register 2");
                    end
                end else begin
                    check_eq(latch, 1'b0, "latch between init clocks");
                end
            end else begin
                sf = (latch_n / 32) % 255;
                if (sclk) begin
                    check_eq(blank, 1'b0, "blank during row shift");
                    if ((sf % 16) == 15) begin
                        check_eq({panel.rgb_upper, panel.rgb_lower}, 6'd0,
                                 $sformatf("rgb lit in stolen subframe %0d", sf));
                    end else if (colour_on && row_pulses < 64) begin
                        level_cmp = reverse_bits(8'(sf));
                        key = (latch_n % 32) * 64 + row_pulses;
                        idx = entry_at[key];
                        if (idx >= 0) begin
                            check_eq(panel.rgb_upper, expected_rgb(tab_level[idx], level_cmp),
                                     $sformatf("upper entry %0d subframe %0d", idx, sf));
                            tab_seen[idx]++;
                        end
                        idx = entry_at[2048 + key];
                        if (idx >= 0) begin
                            check_eq(panel.rgb_lower, expected_rgb(tab_level[idx], level_cmp),
                                     $sformatf("lower entry %0d subframe %0d", idx, sf));
                            tab_seen[idx]++;
                        end
                    end
                    row_pulses++;
                end
                if (latch && !prev_latch) begin
                    check_eq(row_pulses, 64, $sformatf("sclk pulses in row %0d", latch_n));
                    check_eq(blank, 1'b1, "blank during latch");
                    if (latch_n > 0) begin
                        check_eq(cycle - last_latch_cyc, ROW_CYCLES, "cycles between latches");
                    end
                    last_latch_cyc = cycle;
                    latch_n++;
                    row_pulses = 0;
                    if (colour_on && (latch_n % 32) == 0) begin
                        sf_seen++;
                    end
                end
                // the last init latch also falls here, before any row latch
                if (!latch && prev_latch && latch_n > 0) begin
                    check_eq(panel.addr, (latch_n - 1) % 32, "row address after latch");
                end
            end
            prev_latch = latch;
        end
    end

endmodule

/* verilog/led_panel_top.sv */
`timescale 1ns/1ps

module led_panel_top (
    input  logic                        clk,
    input  logic                        pll_locked,
    input  led_panel_pkg::pixel_write_t pix_wr,
    output logic                        credit_return,
    output led_panel_pkg::panel_out_t   panel,
    output logic                        blank,
    output logic                        latch,
    output logic                        sclk
);

    logic                        ready;
    led_panel_pkg::scan_pos_t    scan_pos;
    led_panel_pkg::scan_pos_t    scan_late;   // lines up with the read data
    led_panel_pkg::pixel_write_t wr;
    led_panel_pkg::rgb565_t      pix_upper;
    led_panel_pkg::rgb565_t      pix_lower;
    logic [2:0]                  rgb_upper;
    logic [2:0]                  rgb_lower;

    scan_timer u_scan_timer (
        .clk        (clk),
        .pll_locked (pll_locked),
        .ready      (ready),
        .scan_pos   (scan_pos)
    );

    // host writes wait here for a stolen subframe
    pixel_write_queue u_pixel_write_queue (
        .clk           (clk),
        .pll_locked    (pll_locked),
        .pix_wr        (pix_wr),
        .steal         (scan_pos.steal),
        .wr            (wr),
        .credit_return (credit_return)
    );

    frame_buffer u_frame_buffer (
        .clk       (clk),
        .scan_pos  (scan_pos),
        .wr        (wr),
        .pix_upper (pix_upper),
        .pix_lower (pix_lower),
        .scan_late (scan_late)
    );

    subframe_pwm u_subframe_pwm (
        .pix_upper (pix_upper),
        .pix_lower (pix_lower),
        .scan_late (scan_late),
        .rgb_upper (rgb_upper),
        .rgb_lower (rgb_lower)
    );

    panel_driver u_panel_driver (
        .clk        (clk),
        .pll_locked (pll_locked),
        .rgb_upper  (rgb_upper),
        .rgb_lower  (rgb_lower),
        .scan_pos   (scan_pos),
        .ready      (ready),
        .panel      (panel),
        .blank      (blank),
        .latch      (latch),
        .sclk       (sclk)
    );

endmodule

/* verilog/panel_driver.sv */
`timescale 1ns/1ps
`include "led_panel_macros.svh"

module panel_driver (
    input  logic                      clk,
    input  logic                      pll_locked,
    input  logic [2:0]                rgb_upper,
    input  logic [2:0]                rgb_lower,
    input  led_panel_pkg::scan_pos_t  scan_pos,
    output logic                      ready,
    output led_panel_pkg::panel_out_t panel,
    output logic                      blank,
    output logic                      latch,
    output logic                      sclk
);

    localparam logic [3:0] S_START   = 4'd0;
    localparam logic [3:0] S_R1      = 4'd1;
    localparam logic [3:0] S_R1E     = 4'd2;
    localparam logic [3:0] S_R2      = 4'd3;
    localparam logic [3:0] S_R2E     = 4'd4;
    localparam logic [3:0] S_SDELAY  = 4'd5;
    localparam logic [3:0] S_SHIFT0  = 4'd6;
    localparam logic [3:0] S_SHIFT   = 4'd7;
    localparam logic [3:0] S_SHIFTN  = 4'd8;
    localparam logic [3:0] S_BLANK   = 4'd9;
    localparam logic [3:0] S_UNBLANK = 4'd10;

    logic [3:0]           state;
    logic [15:0]          init_reg;    // FM6126 word, rotated MSB first
    logic [`COL_BITS-1:0] init_cnt;    // clock within the 64 of a register
    logic [`COL_BITS-1:0] latch_len;
    logic [`ROW_BITS-1:0] row_hold;    // row just shifted in

    // scan counter runs from the startup cycle on
    assign ready     = (state >= S_SDELAY);
    assign latch_len = (state == S_R1) ? `FM_LATCH1 : `FM_LATCH2;

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            state    <= S_START;
            init_reg <= `FM_REG1;
            init_cnt <= '0;
            row_hold <= '0;
            panel    <= '0;
            blank    <= 1'b1;
            latch    <= 1'b0;
            sclk     <= 1'b0;
        end else begin
            case (state)
                S_START: begin
                    blank    <= 1'b1;   // dark until the first row latches
                    init_reg <= `FM_REG1;
                    init_cnt <= '0;
                    state    <= S_R1;
                end
                S_R1, S_R2: begin
                    panel.rgb_upper <= {3{init_reg[15]}};
                    panel.rgb_lower <= {3{init_reg[15]}};
                    init_reg        <= {init_reg[14:0], init_reg[15]};
                    latch           <= (~init_cnt < latch_len); // last n clocks
                    sclk            <= 1'b1;
                    init_cnt        <= init_cnt + 1'b1;
                    if (init_cnt == '1) begin
                        state <= (state == S_R1) ? S_R1E : S_R2E;
                    end
                end
                S_R1E: begin
                    panel.rgb_upper <= 3'b000;
                    panel.rgb_lower <= 3'b000;
                    latch           <= 1'b0;
                    sclk            <= 1'b0;
                    init_reg        <= `FM_REG2;
                    state           <= S_R2;
                end
                S_R2E: begin
                    panel.rgb_upper <= 3'b000;
                    panel.rgb_lower <= 3'b000;
                    latch           <= 1'b0;
                    sclk            <= 1'b0;
                    state           <= S_SDELAY;
                end
                S_SDELAY: begin
                    state <= S_SHIFT0;  // first column read is in flight
                end
                S_SHIFT0: begin
                    panel.rgb_upper <= rgb_upper;
                    panel.rgb_lower <= rgb_lower;
                    sclk            <= 1'b1;
                    blank           <= 1'b0;
                    state           <= S_SHIFT;
                end
                S_SHIFT: begin
                    panel.rgb_upper <= rgb_upper;
                    panel.rgb_lower <= rgb_lower;
                    sclk            <= 1'b1;
                    // scan is one column ahead of the pwm data
                    if (scan_pos.column == '1) begin
                        state <= S_SHIFTN;
                    end
                end
                S_SHIFTN: begin
                    panel.rgb_upper <= rgb_upper;
                    panel.rgb_lower <= rgb_lower;
                    sclk            <= 1'b1;
                    state           <= S_BLANK;
                end
                S_BLANK: begin
                    sclk     <= 1'b0;
                    blank    <= 1'b1;
                    latch    <= 1'b1;
                    row_hold <= scan_pos.row;   // still in the gap of this row
                    state    <= S_UNBLANK;
                end
                S_UNBLANK: begin
                    latch      <= 1'b0;
                    panel.addr <= row_hold;     // show the row just latched
                    state      <= S_SHIFT0;
                end
                default: begin
                    state <= S_START;
                end
            endcase
        end
    end

endmodule

/* verilog/subframe_pwm.sv */
`timescale 1ns/1ps
`include "led_panel_macros.svh"

module subframe_pwm (
    input  led_panel_pkg::rgb565_t   pix_upper,
    input  led_panel_pkg::rgb565_t   pix_lower,
    input  led_panel_pkg::scan_pos_t scan_late,
    output logic [2:0]               rgb_upper,
    output logic [2:0]               rgb_lower
);

    logic [`SUBFRAME_BITS-1:0] cmp;

    // bit-reversed subframe spreads the on time, less visible flicker
    always_comb begin
        for (int i = 0; i < `SUBFRAME_BITS; i++) begin
            cmp[i] = scan_late.subframe[`SUBFRAME_BITS-1-i];
        end
    end

    // red, green, blue on bits 2, 1, 0
    function automatic logic [2:0] lit(input led_panel_pkg::rgb565_t pix,
                                       input logic [`SUBFRAME_BITS-1:0] level);
        lit[2] = {pix.red, 3'b000} > level;
        lit[1] = {pix.green, 2'b00} > level;
        lit[0] = {pix.blue, 3'b000} > level;
    endfunction

    assign rgb_upper = scan_late.steal ? 3'b000 : lit(pix_upper, cmp);
    assign rgb_lower = scan_late.steal ? 3'b000 : lit(pix_lower, cmp);

endmodule

/* verilog/frame_buffer.sv */
`timescale 1ns/1ps
`include "led_panel_macros.svh"

module frame_buffer (
    input  logic                        clk,
    input  led_panel_pkg::scan_pos_t    scan_pos,
    input  led_panel_pkg::pixel_write_t wr,
    output led_panel_pkg::rgb565_t      pix_upper,
    output led_panel_pkg::rgb565_t      pix_lower,
    output led_panel_pkg::scan_pos_t    scan_late
);

    // rows 0..31 of the panel in one bank, rows 32..63 in the other
    led_panel_pkg::rgb565_t bank_upper [0:(1 << (`ROW_BITS + `COL_BITS)) - 1];
    led_panel_pkg::rgb565_t bank_lower [0:(1 << (`ROW_BITS + `COL_BITS)) - 1];

    logic [`ROW_BITS+`COL_BITS-1:0] rd_addr;
    logic [`ROW_BITS+`COL_BITS-1:0] wr_addr;
    logic                           wr_upper;
    logic                           wr_lower;

    assign rd_addr  = {scan_pos.row, scan_pos.column};
    assign wr_addr  = {wr.row, wr.column};
    assign wr_upper = wr.valid && !wr.half;
    assign wr_lower = wr.valid && wr.half;

    always_ff @(posedge clk) begin
        if (wr_upper) begin
            bank_upper[wr_addr] <= wr.pixel;
        end
        pix_upper <= bank_upper[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (wr_lower) begin
            bank_lower[wr_addr] <= wr.pixel;
        end
        pix_lower <= bank_lower[rd_addr];
    end

    always_ff @(posedge clk) begin
        scan_late <= scan_pos;   // same latency as the bank reads
    end

endmodule

/* verilog/pixel_write_queue.sv */
`timescale 1ns/1ps
`include "led_panel_macros.svh"

module pixel_write_queue (
    input  logic                        clk,
    input  logic                        pll_locked,
    input  led_panel_pkg::pixel_write_t pix_wr,
    input  logic                        steal,
    output led_panel_pkg::pixel_write_t wr,
    output logic                        credit_return
);

    led_panel_pkg::pixel_write_t entries [0:(1 << `QUEUE_PTR_BITS) - 1];

    logic [`QUEUE_PTR_BITS-1:0] wr_ptr;
    logic [`QUEUE_PTR_BITS-1:0] rd_ptr;
    logic [`QUEUE_PTR_BITS:0]   count;
    logic                       push;
    logic                       pop;

    // host spends a credit per write, so a full queue means a broken host
    assign push = pix_wr.valid && (count != `QUEUE_DEPTH);
    assign pop  = steal && (count != '0);

    // head entry goes straight to the frame buffer, written on this edge
    always_comb begin
        wr       = entries[rd_ptr];
        wr.valid = pop;
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= pix_wr;
        end
    end

    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;   // one credit back the cycle after a pop
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/scan_timer.sv */
`timescale 1ns/1ps
`include "led_panel_macros.svh"

module scan_timer (
    input  logic                     clk,
    input  logic                     pll_locked,
    input  logic                     ready,
    output led_panel_pkg::scan_pos_t scan_pos
);

    logic [`COL_BITS-1:0]      column;
    logic [`ROW_BITS-1:0]      row;
    logic [`SUBFRAME_BITS-1:0] subframe;
    logic [1:0]                gap_cnt;   // idle cycles left, 0 while shifting

    // held at zero until the driver has finished the FM6126 init
    always_ff @(posedge clk or negedge pll_locked) begin
        if (!pll_locked) begin
            column   <= '0;
            row      <= '0;
            subframe <= '0;
            gap_cnt  <= 2'd0;
        end else if (ready) begin
            if (gap_cnt == 2'd0) begin
                column <= column + 1'b1;
                if (column == '1) begin
                    gap_cnt <= `ROW_GAP;   // row shifted, give the driver its gap
                end
            end else begin
                gap_cnt <= gap_cnt - 1'b1;
                if (gap_cnt == 2'd1) begin
                    row <= row + 1'b1;
                    if (row == '1) begin
                        // early wrap so a frame is 255 subframes
                        if (subframe == `LAST_SUBFRAME) begin
                            subframe <= '0;
                        end else begin
                            subframe <= subframe + 1'b1;
                        end
                    end
                end
            end
        end
    end

    assign scan_pos.subframe = subframe;
    assign scan_pos.row      = row;
    assign scan_pos.column   = column;
    assign scan_pos.steal    = &subframe[`STEAL_BITS-1:0]; // every 16th subframe
    assign scan_pos.shift    = (gap_cnt == 2'd0);

endmodule

/* verilog/led_panel_pkg.sv */
`include "led_panel_macros.svh"

package led_panel_pkg;

    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565_t;

    // one pixel write from the host
    typedef struct packed {
        logic                 valid;
        logic                 half;   // 0 selects the upper half
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] column;
        rgb565_t              pixel;
    } pixel_write_t;

    // where the scan is right now
    typedef struct packed {
        logic [`SUBFRAME_BITS-1:0] subframe;
        logic [`ROW_BITS-1:0]      row;
        logic [`COL_BITS-1:0]      column;
        logic                      steal;  // subframe handed to the writes
        logic                      shift;  // low in the row gap
    } scan_pos_t;

    // colour and address pins of the panel connector
    typedef struct packed {
        logic [2:0]           rgb_upper;
        logic [2:0]           rgb_lower;
        logic [`ROW_BITS-1:0] addr;
    } panel_out_t;

endpackage

/* include/led_panel_macros.svh */
`ifndef LED_PANEL_MACROS_SVH
`define LED_PANEL_MACROS_SVH

// panel geometry, one half of the panel
`define COL_BITS        6
`define ROW_BITS        5

// pseudo-PWM subframes
`define SUBFRAME_BITS   8
`define STEAL_BITS      4      // steal when these low bits are all ones
`define LAST_SUBFRAME   8'd254 // wrap one early, 255 subframes per frame

// idle cycles after the 64 columns of a row
`define ROW_GAP         2'd2

// host write queue, also the credits held after reset
`define QUEUE_DEPTH     4'd8
`define QUEUE_PTR_BITS  3

// FM6126 configuration words and their latched clock counts
`define FM_REG1         16'h7FFF
`define FM_REG2         16'h0040
`define FM_LATCH1       6'd11
`define FM_LATCH2       6'd12

`endif
